// ==== Bender.yml ====
package:
  name: torpedo_game_core

sources:
  - include_dirs:
      - src
    files:
      - src/game_pkg.sv
      - src/game_master_fsm.sv
      - src/sprite_motion.sv
      - src/sprite_overlap_detector.sv
      - src/end_of_game_timer.sv
      - src/game_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - test/tb_game_top.sv

// ==== filelist.f ====
+incdir+src
src/game_pkg.sv
src/game_master_fsm.sv
src/sprite_motion.sv
src/sprite_overlap_detector.sv
src/end_of_game_timer.sv
src/game_top.sv
test/tb_game_top.sv

// ==== src/end_of_game_timer.sv ====
`timescale 1ns/1ps

`include "game_settings.svh"

module end_of_game_timer
(
    input  logic clk,
    input  logic reset,

    input  logic start,
    input  logic frame_tick,

    output logic running
);

    logic [7:0] frames_left;

    // Counts frames down to zero, a new start reloads.
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            frames_left <= '0;
        else if (start)
            frames_left <= `END_TIMER_FRAMES;
        else if (frame_tick && running)
            frames_left <= frames_left - 8'd1;
    end

    assign running = (frames_left != 8'd0);

endmodule

// ==== src/game_master_fsm.sv ====
`timescale 1ns/1ps

module game_master_fsm
    import game_pkg::*;
(
    input  logic         clk,
    input  logic         reset,

    input  logic         key,

    input  logic         target_on_screen,
    input  logic         torpedo_on_screen,
    input  logic         collision,
    input  logic         timer_running,

    output sprite_ctrl_t target_ctrl,
    output sprite_ctrl_t torpedo_ctrl,

    output logic         timer_start,
    output logic         game_won
);

    typedef enum logic [2:0]
    {
        st_start_target    = 3'd0,
        st_wait_key        = 3'd1,
        st_start_torpedo   = 3'd2,
        st_wait_collision  = 3'd3,
        st_start_end_timer = 3'd4,
        st_game_won        = 3'd5,
        st_game_lost       = 3'd6
    }
    state_t;

    state_t state;
    state_t next_state;

    logic   end_of_game;
    logic   collision_reg;

    // A hit or either sprite off screen finishes the round.
    assign end_of_game = collision | ~target_on_screen | ~torpedo_on_screen;

    // Keeps the collision that ended the game for the decision
    // one cycle later.
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            collision_reg <= 1'b0;
        else
            collision_reg <= collision;
    end

    always_comb
    begin
        next_state = state;

        case (state)
            st_start_target:
                next_state = st_wait_key;

            st_wait_key:
            begin
                if (key)
                    next_state = st_start_torpedo;
                else if (end_of_game)
                    next_state = st_start_end_timer;
            end

            st_start_torpedo:
                next_state = st_wait_collision;

            st_wait_collision:
            begin
                if (end_of_game)
                    next_state = st_start_end_timer;
            end

            st_start_end_timer:
            begin
                if (collision_reg)
                    next_state = st_game_won;
                else
                    next_state = st_game_lost;
            end

            st_game_won,
            st_game_lost:
            begin
                if (!timer_running)
                    next_state = st_start_target;
            end

            default:
                next_state = st_start_target;
        endcase
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            state <= st_start_target;
        else
            state <= next_state;
    end

    // Target is placed once and then flies in both wait states.
    assign target_ctrl.write_xy       = (state == st_start_target);
    assign target_ctrl.write_dxy      = (state == st_start_target);
    assign target_ctrl.enable_update  = (state == st_wait_key)
                                      | (state == st_wait_collision);

    // Torpedo velocity follows steer so it applies on the next update.
    assign torpedo_ctrl.write_xy      = (state == st_start_target);
    assign torpedo_ctrl.write_dxy     = (state == st_wait_key)
                                      | (state == st_wait_collision);
    assign torpedo_ctrl.enable_update = (state == st_wait_collision);

    assign timer_start = (state == st_start_end_timer);
    assign game_won    = (state == st_game_won);

endmodule

// ==== src/game_pkg.sv ====
`include "game_settings.svh"

package game_pkg;

    // Top left corner of a sprite box.
    typedef struct packed
    {
        logic signed [`COORD_W - 1:0] x;
        logic signed [`COORD_W - 1:0] y;
    }
    sprite_pos_t;

    // Per-frame displacement, negative dy moves up.
    typedef struct packed
    {
        logic signed [7:0] dx;
        logic signed [7:0] dy;
    }
    sprite_vel_t;

    // Command from the master FSM to one sprite.
    typedef struct packed
    {
        logic write_xy;
        logic write_dxy;
        logic enable_update;
    }
    sprite_ctrl_t;

    // Player steering input for the torpedo.
    typedef enum logic [1:0]
    {
        steer_none  = 2'd0,
        steer_left  = 2'd1,
        steer_right = 2'd2
    }
    steer_t;

endpackage

// ==== src/game_settings.svh ====
`ifndef GAME_SETTINGS_SVH
`define GAME_SETTINGS_SVH

// Visible screen area in pixels.
`define SCREEN_W            10'd640
`define SCREEN_H            10'd480

// Signed coordinates so that a sprite leaving the screen
// shows up as a negative value or a value past the edge.
`define COORD_W             11

// Sprite bounding boxes.
`define TARGET_W            32
`define TARGET_H            16
`define TORPEDO_W           4
`define TORPEDO_H           12

// Start positions, top left corner of each box.
`define TARGET_START_X      0
`define TARGET_START_Y      40
`define TORPEDO_START_X     318
`define TORPEDO_START_Y     460

// Speeds in pixels per frame.
`define TARGET_DX           4
`define TORPEDO_DY          8
`define STEER_DX            2

// Frames the result stays on screen before restart.
`define END_TIMER_FRAMES    8'd4

`endif

// ==== src/game_top.sv ====
`timescale 1ns/1ps

`include "game_settings.svh"

module game_top
    import game_pkg::*;
(
    input  logic        clk,
    input  logic        reset,

    input  logic        key,
    input  steer_t      steer,
    input  logic        frame_tick,

    output sprite_pos_t target_pos,
    output sprite_pos_t torpedo_pos,

    output logic        game_won,
    output logic        game_over
);

    sprite_ctrl_t target_ctrl;
    sprite_ctrl_t torpedo_ctrl;
    sprite_vel_t  target_vel;
    sprite_vel_t  torpedo_vel;

    logic         target_on_screen;
    logic         torpedo_on_screen;
    logic         collision;
    logic         timer_start;
    logic         timer_running;

    // Target crosses left to right at a fixed speed.
    assign target_vel.dx = 8'(`TARGET_DX);
    assign target_vel.dy = 8'sd0;

    // Torpedo always climbs, steer only adds sideways drift.
    always_comb
    begin
        torpedo_vel.dy = 8'(-`TORPEDO_DY);

        case (steer)
            steer_left:  torpedo_vel.dx = 8'(-`STEER_DX);
            steer_right: torpedo_vel.dx = 8'(`STEER_DX);
            default:     torpedo_vel.dx = 8'sd0;
        endcase
    end

    game_master_fsm u_fsm
    (
        .clk               (clk),
        .reset             (reset),
        .key               (key),
        .target_on_screen  (target_on_screen),
        .torpedo_on_screen (torpedo_on_screen),
        .collision         (collision),
        .timer_running     (timer_running),
        .target_ctrl       (target_ctrl),
        .torpedo_ctrl      (torpedo_ctrl),
        .timer_start       (timer_start),
        .game_won          (game_won)
    );

    sprite_motion
    #(
        .START_X  (`TARGET_START_X),
        .START_Y  (`TARGET_START_Y),
        .SPRITE_W (`TARGET_W),
        .SPRITE_H (`TARGET_H)
    )
    u_target
    (
        .clk           (clk),
        .reset         (reset),
        .ctrl          (target_ctrl),
        .frame_tick    (frame_tick),
        .vel           (target_vel),
        .pos           (target_pos),
        .within_screen (target_on_screen)
    );

    sprite_motion
    #(
        .START_X  (`TORPEDO_START_X),
        .START_Y  (`TORPEDO_START_Y),
        .SPRITE_W (`TORPEDO_W),
        .SPRITE_H (`TORPEDO_H)
    )
    u_torpedo
    (
        .clk           (clk),
        .reset         (reset),
        .ctrl          (torpedo_ctrl),
        .frame_tick    (frame_tick),
        .vel           (torpedo_vel),
        .pos           (torpedo_pos),
        .within_screen (torpedo_on_screen)
    );

    sprite_overlap_detector
    #(
        .TARGET_W  (`TARGET_W),
        .TARGET_H  (`TARGET_H),
        .TORPEDO_W (`TORPEDO_W),
        .TORPEDO_H (`TORPEDO_H)
    )
    u_overlap
    (
        .target_pos  (target_pos),
        .torpedo_pos (torpedo_pos),
        .collision   (collision)
    );

    end_of_game_timer u_timer
    (
        .clk        (clk),
        .reset      (reset),
        .start      (timer_start),
        .frame_tick (frame_tick),
        .running    (timer_running)
    );

    // Result display lasts exactly as long as the timer.
    assign game_over = timer_running;

endmodule

// ==== src/sprite_motion.sv ====
`timescale 1ns/1ps

`include "game_settings.svh"

module sprite_motion
    import game_pkg::*;
#(
    parameter int START_X  = 0,
    parameter int START_Y  = 0,
    parameter int SPRITE_W = 8,
    parameter int SPRITE_H = 8
)
(
    input  logic         clk,
    input  logic         reset,

    input  sprite_ctrl_t ctrl,
    input  logic         frame_tick,
    input  sprite_vel_t  vel,

    output sprite_pos_t  pos,
    output logic         within_screen
);

    // Largest top left corner that keeps the whole box visible.
    localparam int MAX_X = `SCREEN_W - SPRITE_W;
    localparam int MAX_Y = `SCREEN_H - SPRITE_H;

    localparam sprite_pos_t START_POS =
    '{
        x: `COORD_W'(START_X),
        y: `COORD_W'(START_Y)
    };

    sprite_vel_t vel_reg;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            vel_reg <= '0;
        else if (ctrl.write_dxy)
            vel_reg <= vel;
    end

    // Start position load wins over motion.
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            pos <= START_POS;
        end
        else if (ctrl.write_xy)
        begin
            pos <= START_POS;
        end
        else if (ctrl.enable_update && frame_tick)
        begin
            pos.x <= pos.x + vel_reg.dx;
            pos.y <= pos.y + vel_reg.dy;
        end
    end

    assign within_screen = (pos.x >= 0) && (pos.x <= MAX_X)
                        && (pos.y >= 0) && (pos.y <= MAX_Y);

endmodule

// ==== src/sprite_overlap_detector.sv ====
`timescale 1ns/1ps

module sprite_overlap_detector
    import game_pkg::*;
#(
    parameter int TARGET_W  = 32,
    parameter int TARGET_H  = 16,
    parameter int TORPEDO_W = 4,
    parameter int TORPEDO_H = 12
)
(
    input  sprite_pos_t target_pos,
    input  sprite_pos_t torpedo_pos,

    output logic        collision
);

    logic overlap_x;
    logic overlap_y;

    // Boxes overlap on an axis when each one starts
    // before the other one ends.
    assign overlap_x = (target_pos.x  < torpedo_pos.x + TORPEDO_W)
                    && (torpedo_pos.x < target_pos.x  + TARGET_W);

    assign overlap_y = (target_pos.y  < torpedo_pos.y + TORPEDO_H)
                    && (torpedo_pos.y < target_pos.y  + TARGET_H);

    assign collision = overlap_x & overlap_y;

endmodule

// ==== test/game_cases.txt ====
name steer(0 none 1 left 2 right) launch_frame(255 never) won end_frame
hit_center_early 0 20 1 72
hit_center 0 25 1 76
hit_center_late 0 28 1 79
miss_center_late 0 30 0 88
miss_right 2 25 0 83
miss_left 1 25 0 83
hit_left 1 2 1 53
hit_right 2 50 1 101
no_launch 0 255 0 153
target_escapes 0 100 0 153

// ==== test/tb_game_top.sv ====
`timescale 1ns/1ps

`include "game_settings.svh"

module tb_game_top
    import game_pkg::*;
;

    localparam int WAIT_LIMIT = 2000;

    logic        clk;
    logic        reset;
    logic        key;
    steer_t      steer;
    logic        frame_tick;

    sprite_pos_t target_pos;
    sprite_pos_t torpedo_pos;
    logic        game_won;
    logic        game_over;

    integer            mismatch_count;
    integer            failure_count;
    integer            current_frame;
    reg [8*32-1:0]     case_name;
    reg [8*128-1:0]    header_line;
    integer            fd;
    integer            code;
    integer            done;
    integer            steer_code;
    integer            launch;
    integer            exp_won;
    integer            exp_end;
    integer            seed;
    integer            rnd;
    integer            run;

    game_top u_dut
    (
        .clk         (clk),
        .reset       (reset),
        .key         (key),
        .steer       (steer),
        .frame_tick  (frame_tick),
        .target_pos  (target_pos),
        .torpedo_pos (torpedo_pos),
        .game_won    (game_won),
        .game_over   (game_over)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task check_value(input string what, input integer expected, input integer actual);
    begin
        if (expected != actual)
        begin
            $display("mismatch %0s frame %0d %0s: expected %0d, actual %0d",
                     case_name, current_frame, what, expected, actual);
            mismatch_count = mismatch_count + 1;
        end
    end
    endtask

    // One frame is four clocks, the key pulse follows the tick.
    task issue_frame(input logic press_key);
    begin
        frame_tick = 1'b1;
        @(posedge clk);
        #2;
        frame_tick = 1'b0;
        key = press_key;
        @(posedge clk);
        #2;
        key = 1'b0;
        repeat (2) @(posedge clk);
        #2;
    end
    endtask

    task check_start();
    begin
        current_frame = 0;
        check_value("target x", `TARGET_START_X, $signed(target_pos.x));
        check_value("target y", `TARGET_START_Y, $signed(target_pos.y));
        check_value("torpedo x", `TORPEDO_START_X, $signed(torpedo_pos.x));
        check_value("torpedo y", `TORPEDO_START_Y, $signed(torpedo_pos.y));
        check_value("game_won", 0, game_won);
        check_value("game_over", 0, game_over);
    end
    endtask

    // Target moves on every tick, torpedo only after the launch frame.
    task check_motion(input integer frame, input integer launch_frame, input integer steer_dx);
        integer m;
    begin
        current_frame = frame;
        if (frame <= launch_frame)
            m = 0;
        else
            m = frame - launch_frame;
        check_value("target x", `TARGET_START_X + `TARGET_DX * frame, $signed(target_pos.x));
        check_value("target y", `TARGET_START_Y, $signed(target_pos.y));
        check_value("torpedo x", `TORPEDO_START_X + steer_dx * m, $signed(torpedo_pos.x));
        check_value("torpedo y", `TORPEDO_START_Y - `TORPEDO_DY * m, $signed(torpedo_pos.y));
    end
    endtask

    task play_game(input integer steer_sel, input integer launch_frame,
                   input integer won, input integer end_frame);
        integer frame;
        integer cycles;
        integer held;
        integer steer_dx;
        integer over;
    begin
        steer = steer_t'(steer_sel[1:0]);
        if (steer_sel == 1)
            steer_dx = -`STEER_DX;
        else if (steer_sel == 2)
            steer_dx = `STEER_DX;
        else
            steer_dx = 0;
        check_start();

        frame = 0;
        cycles = 0;
        over = 0;
        while (!over && cycles < WAIT_LIMIT)
        begin
            frame = frame + 1;
            issue_frame(frame == launch_frame);
            cycles = cycles + 4;
            check_motion(frame, launch_frame, steer_dx);
            if (game_over)
                over = 1;
        end

        if (!over)
        begin
            $display("Timeout in %0s while waiting for game_over to rise", case_name);
            failure_count = failure_count + 1;
        end
        else
        begin
            check_value("end frame", end_frame, frame);
            check_value("game_won", won, game_won);

            // Result display lasts a fixed number of ticks.
            held = 0;
            cycles = 0;
            while (game_over && cycles < WAIT_LIMIT)
            begin
                issue_frame(1'b0);
                held = held + 1;
                cycles = cycles + 4;
                // The result holds for the whole display.
                if (game_over)
                    check_value("game_won", won, game_won);
            end
            if (game_over)
            begin
                $display("Timeout in %0s while waiting for game_over to fall", case_name);
                failure_count = failure_count + 1;
            end
            else
            begin
                check_value("result frames", `END_TIMER_FRAMES, held);
            end
        end
    end
    endtask

    initial
    begin
        mismatch_count = 0;
        failure_count = 0;
        current_frame = 0;
        case_name = "reset";
        reset = 1'b1;
        key = 1'b0;
        steer = steer_none;
        frame_tick = 1'b0;

        repeat (2) @(posedge clk);
        #2;
        reset = 1'b0;
        @(posedge clk);
        #2;

        fd = $fopen("test/game_cases.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open the cases file test/game_cases.txt");
            failure_count = failure_count + 1;
        end
        else
        begin
            code = $fgets(header_line, fd);
            done = 0;
            while (!done)
            begin
                code = $fscanf(fd, "%s %d %d %d %d\n",
                               case_name, steer_code, launch, exp_won, exp_end);
                if (code == 5)
                begin
                    play_game(steer_code, launch, exp_won, exp_end);
                end
                else
                begin
                    if (!$feof(fd))
                    begin
                        $display("Could not read a line of the cases file");
                        failure_count = failure_count + 1;
                    end
                    done = 1;
                end
            end
            $fclose(fd);
        end

        // Sideways launches between frames 10 and 40 always miss the target,
        // so the torpedo leaves the top edge after start_y / dy + 1 frames.
        seed = 32'hcdb5;
        case_name = "random_edge_miss";
        for (run = 0; run < 3; run = run + 1)
        begin
            rnd = $random(seed);
            steer_code = rnd[0] ? 2 : 1;
            launch = 10 + ((rnd >> 1) & 32'h7fff) % 31;
            play_game(steer_code, launch, 0, launch + `TORPEDO_START_Y / `TORPEDO_DY + 1);
        end

        case_name = "final";
        check_start();

        $display("Errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule
